// File: int_mem.f
+incdir+rtl
rtl/int_mem_pkg.sv
rtl/data_bus_split.sv
rtl/boot_ctrl.sv
rtl/ibus_merge.sv
rtl/dp_sram.sv
rtl/int_mem.sv
sim/tb_int_mem.sv

// File: rtl/boot_ctrl.sv
`timescale 1ns/1ns
`include "int_mem_cfg.svh"

module boot_ctrl (
   input  logic                    clk_i,
   input  logic                    reset_i,
   // control register slave
   input  logic                    reg_valid_i,
   input  int_mem_pkg::word_t      reg_wdata_i,
   input  int_mem_pkg::strb_t      reg_wstrb_i,
   output logic                    reg_rvalid_o,
   output int_mem_pkg::word_t      reg_rdata_o,
   // status
   output logic                    boot_o,
   output logic                    cpu_reset_o,
   // boot rom read port
   output logic                    rom_r_valid_o,
   output int_mem_pkg::rom_addr_t  rom_r_addr_o,
   input  int_mem_pkg::word_t      rom_r_rdata_i,
   // copy write stream towards the sram
   output logic                    cp_valid_o,
   output int_mem_pkg::sram_addr_t cp_addr_o,
   output int_mem_pkg::word_t      cp_wdata_o
);

   int_mem_pkg::boot_state_t state_q;
   int_mem_pkg::rom_addr_t   rd_cnt_q;
   int_mem_pkg::sram_addr_t  wr_addr_q;
   int_mem_pkg::word_t       rdata_q;
   logic                     go_q;
   logic                     wr_pend_q;
   logic                     boot_q;
   logic                     rst_pulse_q;
   logic                     rvalid_q;
   logic                     reg_write;
   logic                     reg_read;
   logic                     last_rd;

   assign reg_write = reg_valid_i & (|reg_wstrb_i);
   assign reg_read  = reg_valid_i & ~(|reg_wstrb_i);

   // control register: bit 0 boot flag, bit 1 cpu reset request
   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         boot_q      <= 1'b1;
         rst_pulse_q <= 1'b0;
         rvalid_q    <= 1'b0;
      end else begin
         rst_pulse_q <= reg_write & reg_wdata_i[1];
         rvalid_q    <= reg_read;
         if (reg_write) begin
            boot_q <= reg_wdata_i[0];
         end
      end
   end

   always_ff @(posedge clk_i) begin
      if (reg_read) begin
         rdata_q <= int_mem_pkg::word_t'(boot_q);
      end
   end

   // rom reads start one cycle after reset is released
   assign rom_r_valid_o = go_q & (state_q == int_mem_pkg::copy);
   assign rom_r_addr_o  = rd_cnt_q;
   assign last_rd       = rom_r_valid_o & (&rd_cnt_q);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         state_q   <= int_mem_pkg::copy;
         go_q      <= 1'b0;
         rd_cnt_q  <= '0;
         wr_pend_q <= 1'b0;
      end else begin
         go_q      <= 1'b1;
         wr_pend_q <= rom_r_valid_o;
         if (rom_r_valid_o) begin
            rd_cnt_q <= rd_cnt_q + 1'b1;
         end
         case (state_q)
            int_mem_pkg::copy: begin
               if (last_rd) begin
                  state_q <= int_mem_pkg::drain;
               end
            end
            // last write still in flight
            int_mem_pkg::drain: state_q <= int_mem_pkg::run;
            default: state_q <= int_mem_pkg::run;
         endcase
      end
   end

   // write address of the word now being read, relocated to the top
   always_ff @(posedge clk_i) begin
      if (rom_r_valid_o) begin
         wr_addr_q <= `INT_MEM_BOOT_OFFSET + int_mem_pkg::sram_addr_t'(rd_cnt_q);
      end
   end

   assign cp_valid_o   = wr_pend_q;
   assign cp_addr_o    = wr_addr_q;
   assign cp_wdata_o   = rom_r_rdata_i;
   assign boot_o       = boot_q;
   assign cpu_reset_o  = (state_q != int_mem_pkg::run) | rst_pulse_q;
   assign reg_rvalid_o = rvalid_q;
   assign reg_rdata_o  = rdata_q;

   a_copy_in_boot: assert property (@(posedge clk_i) disable iff (reset_i)
      cp_valid_o |-> (state_q inside {int_mem_pkg::copy, int_mem_pkg::drain}));

endmodule

// File: rtl/data_bus_split.sv
`timescale 1ns/1ns

module data_bus_split (
   input  logic                    clk_i,
   input  logic                    reset_i,
   // processor data master with the address already relocated
   input  logic                    m_valid_i,
   input  int_mem_pkg::sram_addr_t m_addr_i,
   input  logic                    m_sel_reg_i,
   input  int_mem_pkg::word_t      m_wdata_i,
   input  int_mem_pkg::strb_t      m_wstrb_i,
   output logic                    m_rvalid_o,
   output int_mem_pkg::word_t      m_rdata_o,
   // boot control register
   output logic                    reg_valid_o,
   input  int_mem_pkg::word_t      reg_rdata_i,
   // sram data port
   output logic                    sram_valid_o,
   output int_mem_pkg::sram_addr_t sram_addr_o,
   output int_mem_pkg::word_t      sram_wdata_o,
   output int_mem_pkg::strb_t      sram_wstrb_o,
   input  int_mem_pkg::word_t      sram_rdata_i
);

   logic m_read;
   logic rd_pend_q;
   logic rd_reg_q;

   // target decode
   assign reg_valid_o  = m_valid_i & m_sel_reg_i;
   assign sram_valid_o = m_valid_i & ~m_sel_reg_i;
   assign sram_addr_o  = m_addr_i;
   assign sram_wdata_o = m_wdata_i;
   assign sram_wstrb_o = m_wstrb_i;

   // zero strobe means read
   assign m_read = m_valid_i & ~(|m_wstrb_i);

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_pend_q <= 1'b0;
      end else begin
         rd_pend_q <= m_read;
      end
   end

   // which target the pending read went to
   always_ff @(posedge clk_i) begin
      if (m_read) begin
         rd_reg_q <= m_sel_reg_i;
      end
   end

   assign m_rvalid_o = rd_pend_q;
   assign m_rdata_o  = rd_reg_q ? reg_rdata_i : sram_rdata_i;

endmodule

// File: rtl/dp_sram.sv
`timescale 1ns/1ns
`include "int_mem_cfg.svh"

module dp_sram (
   input  logic                    clk_i,
   // port a
   input  logic                    a_valid_i,
   input  int_mem_pkg::sram_addr_t a_addr_i,
   input  int_mem_pkg::word_t      a_wdata_i,
   input  int_mem_pkg::strb_t      a_wstrb_i,
   output int_mem_pkg::word_t      a_rdata_o,
   // port b
   input  logic                    b_valid_i,
   input  int_mem_pkg::sram_addr_t b_addr_i,
   input  int_mem_pkg::word_t      b_wdata_i,
   input  int_mem_pkg::strb_t      b_wstrb_i,
   output int_mem_pkg::word_t      b_rdata_o
);

   localparam int DEPTH   = 2 ** (`INT_MEM_SRAM_ADDR_W - 2);
   localparam int N_BYTES = `INT_MEM_DATA_W / 8;

   int_mem_pkg::word_t mem [DEPTH];
   int_mem_pkg::word_t a_rdata_q;
   int_mem_pkg::word_t b_rdata_q;

   // both ports in one process; same-word writes are undefined
   always_ff @(posedge clk_i) begin
      if (a_valid_i) begin
         for (int i = 0; i < N_BYTES; i++) begin
            if (a_wstrb_i[i]) begin
               mem[a_addr_i][i*8 +: 8] <= a_wdata_i[i*8 +: 8];
            end
         end
         if (a_wstrb_i == '0) begin
            a_rdata_q <= mem[a_addr_i];
         end
      end
      if (b_valid_i) begin
         for (int i = 0; i < N_BYTES; i++) begin
            if (b_wstrb_i[i]) begin
               mem[b_addr_i][i*8 +: 8] <= b_wdata_i[i*8 +: 8];
            end
         end
         if (b_wstrb_i == '0) begin
            b_rdata_q <= mem[b_addr_i];
         end
      end
   end

   assign a_rdata_o = a_rdata_q;
   assign b_rdata_o = b_rdata_q;

endmodule

// File: rtl/ibus_merge.sv
`timescale 1ns/1ns

module ibus_merge (
   input  logic                    clk_i,
   input  logic                    reset_i,
   // copy write stream that always wins
   input  logic                    cp_valid_i,
   input  int_mem_pkg::sram_addr_t cp_addr_i,
   input  int_mem_pkg::word_t      cp_wdata_i,
   // processor instruction fetches
   input  logic                    rd_valid_i,
   input  int_mem_pkg::sram_addr_t rd_addr_i,
   output logic                    rd_ready_o,
   output logic                    rd_rvalid_o,
   output int_mem_pkg::word_t      rd_rdata_o,
   // sram port a
   output logic                    sram_valid_o,
   output int_mem_pkg::sram_addr_t sram_addr_o,
   output int_mem_pkg::word_t      sram_wdata_o,
   output int_mem_pkg::strb_t      sram_wstrb_o,
   input  int_mem_pkg::word_t      sram_rdata_i
);

   logic rd_grant;
   logic rd_pend_q;

   // fetch goes through only with no copy write
   assign rd_ready_o = ~cp_valid_i;
   assign rd_grant   = rd_valid_i & ~cp_valid_i;

   assign sram_valid_o = cp_valid_i | rd_grant;
   assign sram_addr_o  = cp_valid_i ? cp_addr_i : rd_addr_i;
   assign sram_wdata_o = cp_valid_i ? cp_wdata_i : '0;
   // copy writes whole words
   assign sram_wstrb_o = cp_valid_i ? '1 : '0;

   always_ff @(posedge clk_i) begin
      if (reset_i) begin
         rd_pend_q <= 1'b0;
      end else begin
         rd_pend_q <= rd_grant;
      end
   end

   assign rd_rvalid_o = rd_pend_q;
   assign rd_rdata_o  = sram_rdata_i;

   // a stalled fetch stays on the bus until it is taken
   a_fetch_held: assert property (@(posedge clk_i) disable iff (reset_i)
      rd_valid_i && !rd_ready_o |=> rd_valid_i && $stable(rd_addr_i));

endmodule

// File: rtl/int_mem.sv
`timescale 1ns/1ns
`include "int_mem_cfg.svh"

module int_mem (
   input  logic                          clk_i,
   input  logic                          reset_i,
   // instruction bus, read only
   input  logic                          i_valid_i,
   input  logic [`INT_MEM_ADDR_W-1:0]    i_addr_i,
   output logic                          i_ready_o,
   output logic                          i_rvalid_o,
   output int_mem_pkg::word_t            i_rdata_o,
   // data bus
   input  logic                          d_valid_i,
   input  logic [`INT_MEM_ADDR_W-1:0]    d_addr_i,
   input  int_mem_pkg::word_t            d_wdata_i,
   input  int_mem_pkg::strb_t            d_wstrb_i,
   output logic                          d_ready_o,
   output logic                          d_rvalid_o,
   output int_mem_pkg::word_t            d_rdata_o,
   // boot rom
   output logic                          rom_r_valid_o,
   output int_mem_pkg::rom_addr_t        rom_r_addr_o,
   input  int_mem_pkg::word_t            rom_r_rdata_i,
   // status
   output logic                          boot_o,
   output logic                          cpu_reset_o
);

   int_mem_pkg::sram_addr_t i_word;
   int_mem_pkg::sram_addr_t d_word;
   int_mem_pkg::sram_addr_t i_word_rel;
   int_mem_pkg::sram_addr_t d_word_rel;

   logic                    reg_valid;
   logic                    reg_rvalid;
   int_mem_pkg::word_t      reg_rdata;

   logic                    cp_valid;
   int_mem_pkg::sram_addr_t cp_addr;
   int_mem_pkg::word_t      cp_wdata;

   logic                    sa_valid;
   int_mem_pkg::sram_addr_t sa_addr;
   int_mem_pkg::word_t      sa_wdata;
   int_mem_pkg::strb_t      sa_wstrb;
   int_mem_pkg::word_t      sa_rdata;
   logic                    sb_valid;
   int_mem_pkg::sram_addr_t sb_addr;
   int_mem_pkg::word_t      sb_wdata;
   int_mem_pkg::strb_t      sb_wstrb;
   int_mem_pkg::word_t      sb_rdata;

   // byte to word address, shifted down by the rom size while booting
   assign i_word     = i_addr_i[`INT_MEM_SRAM_ADDR_W-1:2];
   assign d_word     = d_addr_i[`INT_MEM_SRAM_ADDR_W-1:2];
   assign i_word_rel = boot_o ? i_word + `INT_MEM_BOOT_OFFSET : i_word;
   assign d_word_rel = boot_o ? d_word + `INT_MEM_BOOT_OFFSET : d_word;

   // sram and register both accept every cycle
   assign d_ready_o = 1'b1;

   data_bus_split i_data_bus_split (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .m_valid_i   (d_valid_i),
      .m_addr_i    (d_word_rel),
      .m_sel_reg_i (d_addr_i[`INT_MEM_B_BIT]),
      .m_wdata_i   (d_wdata_i),
      .m_wstrb_i   (d_wstrb_i),
      .m_rvalid_o  (d_rvalid_o),
      .m_rdata_o   (d_rdata_o),
      .reg_valid_o (reg_valid),
      .reg_rdata_i (reg_rdata),
      .sram_valid_o(sb_valid),
      .sram_addr_o (sb_addr),
      .sram_wdata_o(sb_wdata),
      .sram_wstrb_o(sb_wstrb),
      .sram_rdata_i(sb_rdata)
   );

   boot_ctrl i_boot_ctrl (
      .clk_i        (clk_i),
      .reset_i      (reset_i),
      .reg_valid_i  (reg_valid),
      .reg_wdata_i  (d_wdata_i),
      .reg_wstrb_i  (d_wstrb_i),
      .reg_rvalid_o (reg_rvalid),
      .reg_rdata_o  (reg_rdata),
      .boot_o       (boot_o),
      .cpu_reset_o  (cpu_reset_o),
      .rom_r_valid_o(rom_r_valid_o),
      .rom_r_addr_o (rom_r_addr_o),
      .rom_r_rdata_i(rom_r_rdata_i),
      .cp_valid_o   (cp_valid),
      .cp_addr_o    (cp_addr),
      .cp_wdata_o   (cp_wdata)
   );

   ibus_merge i_ibus_merge (
      .clk_i       (clk_i),
      .reset_i     (reset_i),
      .cp_valid_i  (cp_valid),
      .cp_addr_i   (cp_addr),
      .cp_wdata_i  (cp_wdata),
      .rd_valid_i  (i_valid_i),
      .rd_addr_i   (i_word_rel),
      .rd_ready_o  (i_ready_o),
      .rd_rvalid_o (i_rvalid_o),
      .rd_rdata_o  (i_rdata_o),
      .sram_valid_o(sa_valid),
      .sram_addr_o (sa_addr),
      .sram_wdata_o(sa_wdata),
      .sram_wstrb_o(sa_wstrb),
      .sram_rdata_i(sa_rdata)
   );

   dp_sram i_dp_sram (
      .clk_i    (clk_i),
      .a_valid_i(sa_valid),
      .a_addr_i (sa_addr),
      .a_wdata_i(sa_wdata),
      .a_wstrb_i(sa_wstrb),
      .a_rdata_o(sa_rdata),
      .b_valid_i(sb_valid),
      .b_addr_i (sb_addr),
      .b_wdata_i(sb_wdata),
      .b_wstrb_i(sb_wstrb),
      .b_rdata_o(sb_rdata)
   );

   // a register read answer must reach the data bus unchanged
   a_reg_resp: assert property (@(posedge clk_i) disable iff (reset_i)
      reg_rvalid |-> (d_rvalid_o && d_rdata_o == reg_rdata));

endmodule

// File: rtl/int_mem_cfg.svh
`ifndef INT_MEM_CFG_SVH
`define INT_MEM_CFG_SVH

// word width
`define INT_MEM_DATA_W 32

// processor byte address width
`define INT_MEM_ADDR_W 16

// sram byte address width, 4 KB
`define INT_MEM_SRAM_ADDR_W 12

// boot rom byte address width, 256 bytes
`define INT_MEM_ROM_ADDR_W 8

// data address bit selecting the boot control register
`define INT_MEM_B_BIT 15

// minus the rom size in words, wrapped to the sram word address
`define INT_MEM_BOOT_OFFSET \
   ((`INT_MEM_SRAM_ADDR_W - 2)'(-(1 << (`INT_MEM_ROM_ADDR_W - 2))))

`endif

// File: rtl/int_mem_pkg.sv
`include "int_mem_cfg.svh"

package int_mem_pkg;

   // one data word
   typedef logic [`INT_MEM_DATA_W-1:0] word_t;

   // one strobe bit per byte
   typedef logic [`INT_MEM_DATA_W/8-1:0] strb_t;

   // word addresses
   typedef logic [`INT_MEM_SRAM_ADDR_W-3:0] sram_addr_t;
   typedef logic [`INT_MEM_ROM_ADDR_W-3:0] rom_addr_t;

   // boot sequencer states
   typedef enum logic [1:0] {
      copy,
      drain,
      run
   } boot_state_t;

endpackage

// File: run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_int_mem -f int_mem.f -o tb_int_mem
./obj_dir/tb_int_mem | tee sim.log

if grep -q "^Regression passed$" sim.log; then
   exit 0
else
   exit 1
fi

// File: sim/tb_int_mem.sv
`timescale 1ns/1ns
`include "int_mem_cfg.svh"

module tb_int_mem;

   localparam int ROM_WORDS  = 2 ** (`INT_MEM_ROM_ADDR_W - 2);
   localparam int SRAM_WORDS = 2 ** (`INT_MEM_SRAM_ADDR_W - 2);
   localparam logic [31:0] LFSR_TAPS = 32'h80200003;
   localparam logic [15:0] REG_ADDR  = 16'h1 << `INT_MEM_B_BIT;
   // boot, fetches, boot data, register, run
   localparam int TEST_CYCLES = (10 + ROM_WORDS + 4) + (ROM_WORDS + 8) + (2 * 32 + 9)
      + 12 + (16 + ROM_WORDS + 16 + 4 + 8);

   logic clk_i;
   logic reset_i;
   logic i_valid_i;
   logic [15:0] i_addr_i;
   logic i_ready_o;
   logic i_rvalid_o;
   int_mem_pkg::word_t i_rdata_o;
   logic d_valid_i;
   logic [15:0] d_addr_i;
   int_mem_pkg::word_t d_wdata_i;
   int_mem_pkg::strb_t d_wstrb_i;
   logic d_ready_o;
   logic d_rvalid_o;
   int_mem_pkg::word_t d_rdata_o;
   logic rom_r_valid_o;
   int_mem_pkg::rom_addr_t rom_r_addr_o;
   int_mem_pkg::word_t rom_r_rdata_i;
   logic boot_o;
   logic cpu_reset_o;

   logic [31:0] lfsr_q;
   logic boot_model;
   int errors = 0;
   int checks = 0;
   int_mem_pkg::word_t rom_words [ROM_WORDS];
   int_mem_pkg::word_t ref_mem [SRAM_WORDS];
   int_mem_pkg::word_t exp_i [$];
   int_mem_pkg::word_t exp_d [$];
   int_mem_pkg::word_t exp_word;
   logic rom_req = 1'b0;
   int_mem_pkg::rom_addr_t rom_req_addr;

   int_mem i_int_mem (
      .clk_i(clk_i), .reset_i(reset_i),
      .i_valid_i(i_valid_i), .i_addr_i(i_addr_i), .i_ready_o(i_ready_o),
      .i_rvalid_o(i_rvalid_o), .i_rdata_o(i_rdata_o),
      .d_valid_i(d_valid_i), .d_addr_i(d_addr_i), .d_wdata_i(d_wdata_i),
      .d_wstrb_i(d_wstrb_i), .d_ready_o(d_ready_o), .d_rvalid_o(d_rvalid_o),
      .d_rdata_o(d_rdata_o),
      .rom_r_valid_o(rom_r_valid_o), .rom_r_addr_o(rom_r_addr_o),
      .rom_r_rdata_i(rom_r_rdata_i),
      .boot_o(boot_o), .cpu_reset_o(cpu_reset_o)
   );

   always #20 clk_i = ~clk_i;

   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      if (s[0]) begin
         return (s >> 1) ^ LFSR_TAPS;
      end
      return s >> 1;
   endfunction

   // one lfsr step per bit taken
   function logic [31:0] random_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_q = lfsr_step(lfsr_q);
         r = {r[30:0], lfsr_q[0]};
      end
      return r;
   endfunction

   // sram word hit by a processor byte address, moved down by the rom size in boot
   function automatic int sram_index(input logic [15:0] addr, input logic boot);
      int w;
      w = int'(addr[`INT_MEM_SRAM_ADDR_W-1:2]);
      if (boot) begin
         w = (w - ROM_WORDS + SRAM_WORDS) % SRAM_WORDS;
      end
      return w;
   endfunction

   function automatic int_mem_pkg::word_t merge_bytes(input int_mem_pkg::word_t old_w,
         input int_mem_pkg::word_t new_w, input int_mem_pkg::strb_t strb);
      int_mem_pkg::word_t w;
      w = old_w;
      for (int b = 0; b < 4; b++) begin
         if (strb[b]) begin
            w[b*8 +: 8] = new_w[b*8 +: 8];
         end
      end
      return w;
   endfunction

   // rom answers one cycle after the request
   always @(negedge clk_i) begin
      rom_req = rom_r_valid_o;
      rom_req_addr = rom_r_addr_o;
   end

   always @(posedge clk_i) begin
      #2;
      if (rom_req) begin
         rom_r_rdata_i = rom_words[rom_req_addr];
      end
   end

   // response checker for both buses
   always @(negedge clk_i) begin
      if (!reset_i && i_rvalid_o) begin
         checks++;
         assert (exp_i.size() != 0) else begin
            $display("instruction bus returned data that no fetch asked for");
            errors++;
         end
         if (exp_i.size() != 0) begin
            exp_word = exp_i.pop_front();
            assert (i_rdata_o === exp_word) else begin
               $display("[FAIL] i_rdata_o got %h expected %h", i_rdata_o, exp_word);
               errors++;
            end
         end
      end
      if (!reset_i && d_rvalid_o) begin
         checks++;
         assert (exp_d.size() != 0) else begin
            $display("data bus returned data that no read asked for");
            errors++;
         end
         if (exp_d.size() != 0) begin
            exp_word = exp_d.pop_front();
            assert (d_rdata_o === exp_word) else begin
               $display("[FAIL] d_rdata_o got %h expected %h", d_rdata_o, exp_word);
               errors++;
            end
         end
      end
   end

   // holds the fetch until ready, then queues the expected word
   task fetch(input logic [15:0] addr);
      logic taken;
      taken = 1'b0;
      i_valid_i = 1'b1;
      i_addr_i = addr;
      while (!taken) begin
         @(negedge clk_i);
         taken = i_ready_o;
         if (taken) begin
            exp_i.push_back(ref_mem[sram_index(addr, boot_model)]);
         end
         @(posedge clk_i);
         #2;
      end
      i_valid_i = 1'b0;
   endtask

   task data_access(input logic [15:0] addr, input int_mem_pkg::word_t wdata,
         input int_mem_pkg::strb_t strb);
      int idx;
      idx = sram_index(addr, boot_model);
      d_valid_i = 1'b1;
      d_addr_i = addr;
      d_wdata_i = wdata;
      d_wstrb_i = strb;
      if (addr[`INT_MEM_B_BIT]) begin
         if (strb != '0) begin
            boot_model = wdata[0];
         end else begin
            exp_d.push_back(int_mem_pkg::word_t'(boot_model));
         end
      end else if (strb != '0) begin
         ref_mem[idx] = merge_bytes(ref_mem[idx], wdata, strb);
      end else begin
         exp_d.push_back(ref_mem[idx]);
      end
      @(negedge clk_i);
      checks++;
      assert (d_ready_o === 1'b1) else begin
         $display("[FAIL] d_ready_o got %h expected 1", d_ready_o);
         errors++;
      end
      @(posedge clk_i);
      #2;
      d_valid_i = 1'b0;
      d_wstrb_i = '0;
   endtask

   task wait_responses;
      int n;
      n = 0;
      while ((exp_i.size() != 0 || exp_d.size() != 0) && n < 8) begin
         @(posedge clk_i);
         #2;
         n++;
      end
      checks++;
      assert (exp_i.size() == 0 && exp_d.size() == 0) else begin
         $display("responses never arrived: %0d fetches, %0d data reads",
            exp_i.size(), exp_d.size());
         errors++;
      end
   endtask

   task end_test(input int num, input string name, input int err_start);
      $display("test %0d %s: %0d errors", num, name, errors - err_start);
   endtask

   initial begin
      int err0;
      int n;
      clk_i = 1'b0;
      reset_i = 1'b1;
      i_valid_i = 1'b0;
      i_addr_i = '0;
      d_valid_i = 1'b0;
      d_addr_i = '0;
      d_wdata_i = '0;
      d_wstrb_i = '0;
      rom_r_rdata_i = '0;
      lfsr_q = 32'h86194879;
      boot_model = 1'b1;
      for (int k = 0; k < ROM_WORDS; k++) begin
         rom_words[k] = random_bits(32);
      end

      // test 1: boot timing
      err0 = errors;
      repeat (9) @(posedge clk_i);
      @(negedge clk_i);
      checks++;
      assert ({boot_o, cpu_reset_o} === 2'b11) else begin
         $display("[FAIL] {boot_o,cpu_reset_o} got %h expected 3", {boot_o, cpu_reset_o});
         errors++;
      end
      assert ({rom_r_valid_o, i_rvalid_o, d_rvalid_o} === 3'b0) else begin
         $display("[FAIL] {rom_r_valid_o,i_rvalid_o,d_rvalid_o} got %h expected 0",
            {rom_r_valid_o, i_rvalid_o, d_rvalid_o});
         errors++;
      end
      @(posedge clk_i);
      #2;
      reset_i = 1'b0;
      @(negedge clk_i);
      checks++;
      assert (rom_r_valid_o === 1'b0) else begin
         $display("[FAIL] rom_r_valid_o got %h expected 0", rom_r_valid_o);
         errors++;
      end
      n = 0;
      while (cpu_reset_o === 1'b1 && n < 200) begin
         @(posedge clk_i);
         n++;
         #1;
         if (n == 10) begin
            checks++;
            assert (i_ready_o === 1'b0) else begin
               $display("[FAIL] i_ready_o got %h expected 0", i_ready_o);
               errors++;
            end
         end
      end
      #1;
      checks++;
      // rom reads, one drain cycle, then run
      assert (n == ROM_WORDS + 2) else begin
         $display("[FAIL] cpu_reset_o fall cycle got %h expected %h", n, ROM_WORDS + 2);
         errors++;
      end
      assert (boot_o === 1'b1) else begin
         $display("[FAIL] boot_o got %h expected 1", boot_o);
         errors++;
      end
      for (int k = 0; k < ROM_WORDS; k++) begin
         ref_mem[sram_index(16'(4 * k), 1'b1)] = rom_words[k];
      end
      end_test(1, "boot timing", err0);

      // test 2: relocated fetches
      err0 = errors;
      for (int k = 0; k < ROM_WORDS; k++) begin
         fetch(16'(4 * k));
      end
      wait_responses();
      end_test(2, "relocated fetches", err0);

      // test 3: upper half of the copy rewritten through the data bus
      err0 = errors;
      for (int k = 32; k < ROM_WORDS; k++) begin
         int_mem_pkg::strb_t strb;
         strb = 4'(random_bits(4));
         if (strb == '0) begin
            strb = 4'hf;
         end
         data_access(16'(4 * k), random_bits(32), strb);
      end
      for (int k = 32; k < ROM_WORDS; k++) begin
         data_access(16'(4 * k), '0, '0);
      end
      data_access(REG_ADDR, '0, '0);
      wait_responses();
      end_test(3, "relocated data", err0);

      // test 4: control register
      err0 = errors;
      checks++;
      assert (cpu_reset_o === 1'b0) else begin
         $display("[FAIL] cpu_reset_o got %h expected 0", cpu_reset_o);
         errors++;
      end
      data_access(REG_ADDR, '0, 4'hf);
      checks++;
      assert (boot_o === 1'b0) else begin
         $display("[FAIL] boot_o got %h expected 0", boot_o);
         errors++;
      end
      data_access(REG_ADDR, '0, '0);
      data_access(REG_ADDR, 32'h2, 4'hf);
      checks++;
      assert (cpu_reset_o === 1'b1) else begin
         $display("[FAIL] cpu_reset_o got %h expected 1", cpu_reset_o);
         errors++;
      end
      @(posedge clk_i);
      #2;
      assert (cpu_reset_o === 1'b0) else begin
         $display("[FAIL] cpu_reset_o got %h expected 0", cpu_reset_o);
         errors++;
      end
      wait_responses();
      end_test(4, "control register", err0);

      // test 5: no relocation once boot is cleared
      err0 = errors;
      for (int k = 0; k < 16; k++) begin
         data_access(16'(4 * k), random_bits(32), 4'hf);
      end
      for (int k = SRAM_WORDS - ROM_WORDS; k < SRAM_WORDS; k++) begin
         fetch(16'(4 * k));
      end
      for (int k = 0; k < 16; k++) begin
         fetch(16'(4 * k));
      end
      for (int k = 0; k < 4; k++) begin
         data_access(16'(4 * k), '0, '0);
      end
      wait_responses();
      end_test(5, "unrelocated access", err0);

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("Regression passed");
      end else begin
         $display("Regression failed");
      end
      $finish;
   end

   initial begin
      #(4 * TEST_CYCLES * 40);
      $display("timeout: tests still running after %0d cycles", 4 * TEST_CYCLES);
      $display("Regression failed");
      $finish;
   end

endmodule
